/* list.f */
hw/snd_pkg.sv
hw/snd_bus.sv
hw/snd_comm.sv
hw/tone_gen.sv
hw/snd_mix.sv
hw/snd_board.sv
bench/snd_checker.sv
bench/snd_board_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and fail when the log reports a failure
verilator --binary --timing -Wno-fatal -f list.f --top-module snd_board_tb -o snd_sim \
    > build.log 2>&1 &&
./obj_dir/snd_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

/* bench/snd_board_tb.sv */
// testbench top that runs a table of bus, port and tone tests against the sound board
`timescale 1ns/1ns
`default_nettype none

module snd_board_tb import snd_pkg::*; ();

typedef enum logic [3:0] {
    OP_WR, OP_RD, OP_STB, OP_FLAG, OP_NMI, OP_MLATCH, OP_MSTB, OP_TONE
} op_t;

// tone rows carry the period in dat, the volume in exp[15:12] and the high level in exp[9:0]
typedef struct packed {
    logic        tokio;
    op_t         op;
    addr_t       adr;
    data_t       dat;
    logic [15:0] exp;
    logic [3:0]  rom_dly;
} test_t;

localparam logic [3:0] CK_READ   = 4'd0;
localparam logic [3:0] CK_FLAG   = 4'd1;
localparam logic [3:0] CK_NMI    = 4'd2;
localparam logic [3:0] CK_LATCH  = 4'd3;
localparam logic [3:0] CK_STBCNT = 4'd4;
localparam logic [3:0] CK_HOLD   = 4'd5;
localparam logic [3:0] CK_HIGH   = 4'd6;
localparam logic [3:0] CK_LOW    = 4'd7;
localparam logic [3:0] CK_WINCLR = 4'd8;

logic        clk, snd_rstn, cen, tokio;
addr_t       wb_adr;
data_t       wb_dat_w, wb_dat_r;
logic        wb_we, wb_cyc, wb_stb, wb_ack;
data_t       snd_latch, main_latch;
logic        snd_stb, main_stb, snd_flag, nmi_n;
rom_addr_t   rom_addr;
logic        rom_cs, rom_ok;
data_t       rom_data;
sample_t     psg;
logic        chk_en;
logic [3:0]  chk_sel;
logic [15:0] chk_exp, chk_row;
int          err_cnt, chk_cnt;
test_t       rows[$];
int unsigned lcg_state = 9;
int          tone_ns = 0;
logic        table_ready = 1'b0;
logic [3:0]  rom_dly;
int          rom_cnt;
logic [1:0]  cen_cnt;

snd_board UUT (.*);

snd_checker chk (
    .clk(clk), .chk_en(chk_en), .chk_sel(chk_sel), .chk_exp(chk_exp), .chk_row(chk_row),
    .wb_adr(wb_adr), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r), .rom_addr(rom_addr),
    .rom_cs(rom_cs), .rom_ok(rom_ok),
    .snd_flag(snd_flag), .nmi_n(nmi_n), .main_latch(main_latch), .main_stb(main_stb),
    .psg(psg), .err_cnt(err_cnt), .chk_cnt(chk_cnt)
);

always #4 clk = ~clk;

// cen every fourth clock
always @(negedge clk) begin
    cen_cnt = cen_cnt + 2'd1;
    cen     = cen_cnt == 2'd3;
end

// ROM answers after rom_dly cycles of rom_cs
always @(negedge clk) begin
    rom_data = rom_addr[7:0] ^ 8'h5a;
    if (rom_cs) begin
        if (rom_cnt >= int'(rom_dly)) rom_ok = 1'b1;
        else                          rom_cnt++;
    end else begin
        rom_ok  = 1'b0;
        rom_cnt = 0;
    end
end

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
endfunction

task automatic add_row(input logic tk, input op_t op, input addr_t adr, input data_t dat,
                       input logic [15:0] exp);
    test_t r;
    r.tokio   = tk;
    r.op      = op;
    r.adr     = adr;
    r.dat     = dat;
    r.exp     = exp;
    r.rom_dly = 4'(lcg_next() % 5);
    rows.push_back(r);
    if (op == OP_TONE) tone_ns += (int'(dat) + 1) * 4 * 5 * 8 + 800;
endtask

task automatic request_check(input logic [3:0] sel, input logic [15:0] exp);
    chk_sel = sel;
    chk_exp = exp;
    chk_en  = 1'b1;
    @(negedge clk);
    chk_en  = 1'b0;
endtask

// one wishbone classic transfer with the read data checked in the ack cycle
task automatic bus_xfer(input logic we, input addr_t adr, input data_t dat,
                        input logic check, input logic [15:0] exp);
    @(negedge clk);
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_we    = we;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    do @(negedge clk); while (!wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (check) request_check(CK_READ, exp);
    else       @(negedge clk); // stb stays low a cycle
endtask

task automatic run_tone(input addr_t base, input data_t per, input logic [15:0] exp);
    bus_xfer(1'b1, base + 16'd2, {4'd0, exp[15:12]}, 1'b0, 16'd0);
    bus_xfer(1'b1, base + 16'd1, 8'h00, 1'b0, 16'd0);
    bus_xfer(1'b1, base, per, 1'b0, 16'd0);
    @(negedge clk);
    request_check(CK_WINCLR, 16'd0);
    repeat ((int'(per) + 1) * 4 * 5) @(negedge clk);
    request_check(CK_HOLD, (16'(per) + 16'd1) * 16'd4);
    request_check(CK_HIGH, {6'd0, exp[9:0]});
    request_check(CK_LOW, 16'd0);
    bus_xfer(1'b0, base, 8'h00, 1'b1, 16'(per));
    bus_xfer(1'b1, base, 8'h00, 1'b0, 16'd0); // mute again
endtask

initial begin
    // board variant 0
    add_row(0, OP_WR, 16'h8000, 8'h11, 0);
    add_row(0, OP_WR, 16'h8fff, 8'ha5, 0);
    add_row(0, OP_RD, 16'h8000, 0, 16'h11);
    add_row(0, OP_RD, 16'h8fff, 0, 16'ha5);
    add_row(0, OP_RD, 16'ha000, 0, 16'hff); // second FM slot
    add_row(0, OP_RD, 16'hb003, 0, 16'hff);
    add_row(0, OP_RD, 16'hc123, 0, 16'hff);
    add_row(0, OP_RD, 16'h0012, 0, 16'h48);
    add_row(0, OP_RD, 16'h7ffe, 0, 16'ha4);
    add_row(0, OP_RD, 16'h3c81, 0, 16'hdb);
    add_row(0, OP_FLAG, 0, 0, 1);
    add_row(0, OP_STB, 0, 8'h3c, 0);
    add_row(0, OP_FLAG, 0, 0, 0);
    add_row(0, OP_NMI, 0, 0, 1);
    add_row(0, OP_WR, 16'hb001, 0, 0);
    add_row(0, OP_NMI, 0, 0, 0);
    add_row(0, OP_RD, 16'hb001, 0, 16'hfc);
    add_row(0, OP_WR, 16'hb002, 0, 0);
    add_row(0, OP_NMI, 0, 0, 1);
    add_row(0, OP_WR, 16'hb001, 0, 0);
    add_row(0, OP_NMI, 0, 0, 0);
    add_row(0, OP_RD, 16'hb000, 0, 16'h3c);
    add_row(0, OP_FLAG, 0, 0, 1);
    add_row(0, OP_NMI, 0, 0, 1);
    add_row(0, OP_MSTB, 0, 0, 0);
    add_row(0, OP_WR, 16'hb000, 8'h77, 0);
    add_row(0, OP_MLATCH, 0, 0, 16'h77);
    add_row(0, OP_MSTB, 0, 0, 1);
    add_row(0, OP_WR, 16'h9004, 8'h55, 0);
    add_row(0, OP_WR, 16'h9005, 8'h02, 0);
    add_row(0, OP_WR, 16'h9006, 8'h0b, 0);
    add_row(0, OP_RD, 16'h9004, 0, 16'h55);
    add_row(0, OP_RD, 16'h9005, 0, 16'h02);
    add_row(0, OP_RD, 16'h9006, 0, 16'h0b);
    add_row(0, OP_WR, 16'h9004, 8'h00, 0);
    add_row(0, OP_WR, 16'h9005, 8'h00, 0);
    add_row(0, OP_TONE, 16'h9000, 8'd3, {4'd5, 12'd80});
    // board variant 1
    add_row(1, OP_RD, 16'h9000, 0, 16'hff);
    add_row(1, OP_RD, 16'hc000, 0, 16'hff);
    add_row(1, OP_WR, 16'h8123, 8'h9e, 0);
    add_row(1, OP_RD, 16'h8123, 0, 16'h9e);
    add_row(1, OP_RD, 16'h1200, 0, 16'h5a);
    add_row(1, OP_RD, 16'h6a37, 0, 16'h6d);
    add_row(1, OP_STB, 0, 8'hc3, 0);
    add_row(1, OP_FLAG, 0, 0, 0);
    add_row(1, OP_WR, 16'h9800, 0, 0);
    add_row(1, OP_NMI, 0, 0, 0);
    add_row(1, OP_WR, 16'h9000, 0, 0);
    add_row(1, OP_NMI, 0, 0, 1);
    add_row(1, OP_WR, 16'h9800, 0, 0);
    add_row(1, OP_NMI, 0, 0, 0);
    add_row(1, OP_RD, 16'ha800, 0, 16'hfc);
    add_row(1, OP_RD, 16'ha000, 0, 16'hc3);
    add_row(1, OP_FLAG, 0, 0, 1);
    add_row(1, OP_NMI, 0, 0, 1);
    add_row(1, OP_MSTB, 0, 0, 0);
    add_row(1, OP_WR, 16'ha000, 8'h42, 0); // reply without strobe
    add_row(1, OP_MLATCH, 0, 0, 16'h42);
    add_row(1, OP_MSTB, 0, 0, 0);
    add_row(1, OP_WR, 16'ha800, 8'h00, 0);
    add_row(1, OP_MSTB, 0, 0, 1);
    add_row(1, OP_MLATCH, 0, 0, 16'h42);
    add_row(1, OP_WR, 16'hb008, 8'h21, 0);
    add_row(1, OP_RD, 16'hb008, 0, 16'h21);
    add_row(1, OP_WR, 16'hb008, 8'h00, 0);
    add_row(1, OP_TONE, 16'hb000, 8'd2, {4'd9, 12'd36});
    table_ready = 1'b1;

    snd_rstn = 1'b0;
    cen = 1'b0;
    cen_cnt = 2'd0;
    tokio = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_we = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    snd_latch = '0;
    snd_stb = 1'b0;
    rom_data = '0;
    rom_ok = 1'b0;
    rom_dly = '0;
    rom_cnt = 0;
    chk_en = 1'b0;
    chk_sel = '0;
    chk_exp = '0;
    chk_row = '0;
    clk = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    snd_rstn = 1'b1;

    foreach (rows[i]) begin
        @(negedge clk);
        tokio   = rows[i].tokio;
        rom_dly = rows[i].rom_dly;
        chk_row = 16'(i);
        case (rows[i].op)
            OP_WR:     bus_xfer(1'b1, rows[i].adr, rows[i].dat, 1'b0, 16'd0);
            OP_RD:     bus_xfer(1'b0, rows[i].adr, 8'h00, 1'b1, rows[i].exp);
            OP_STB: begin
                snd_latch = rows[i].dat;
                snd_stb   = 1'b1;
                repeat (2) @(negedge clk);
                snd_stb   = 1'b0;
                @(negedge clk);
            end
            OP_FLAG:   request_check(CK_FLAG, rows[i].exp);
            OP_NMI:    request_check(CK_NMI, rows[i].exp);
            OP_MLATCH: request_check(CK_LATCH, rows[i].exp);
            OP_MSTB:   request_check(CK_STBCNT, rows[i].exp);
            default:   run_tone(rows[i].adr, rows[i].dat, rows[i].exp);
        endcase
    end

    repeat (4) @(negedge clk);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

// watchdog sized from the table
initial begin
    wait (table_ready);
    #(rows.size() * 400 + tone_ns);
    $display("timeout: the test table did not finish in time");
    $display("Regression failed");
    $finish;
end

endmodule

`default_nettype wire

/* bench/snd_checker.sv */
// testbench checker that compares sound board outputs with expected values on request and counts errors
`timescale 1ns/1ns
`default_nettype none

module snd_checker import snd_pkg::*; (
    input  logic        clk,
    input  logic        chk_en,
    input  logic [3:0]  chk_sel,
    input  logic [15:0] chk_exp,
    input  logic [15:0] chk_row,
    input  addr_t       wb_adr,
    input  logic        wb_ack,
    input  data_t       wb_dat_r,
    input  rom_addr_t   rom_addr,
    input  logic        rom_cs,
    input  logic        rom_ok,
    input  logic        snd_flag,
    input  logic        nmi_n,
    input  data_t       main_latch,
    input  logic        main_stb,
    input  sample_t     psg,
    output int          err_cnt = 0,
    output int          chk_cnt = 0
);

localparam logic [3:0] CK_READ   = 4'd0;
localparam logic [3:0] CK_FLAG   = 4'd1;
localparam logic [3:0] CK_NMI    = 4'd2;
localparam logic [3:0] CK_LATCH  = 4'd3;
localparam logic [3:0] CK_STBCNT = 4'd4;
localparam logic [3:0] CK_HOLD   = 4'd5;
localparam logic [3:0] CK_HIGH   = 4'd6;
localparam logic [3:0] CK_LOW    = 4'd7;

logic        cs_q = 1'b0;
logic        ok_q = 1'b0;
int          stb_cnt = 0;
int          run = 0;
int          last_hold = 0;
sample_t     psg_q = '0;
sample_t     psg_max = '0;
sample_t     psg_min = '1;
logic [15:0] got;
string       name;

// inputs change on the falling edge and settle before the rising edge
always @(posedge clk) begin
    if (ok_q && !wb_ack) begin
        $display("row %0d: no acknowledge one cycle after rom_cs and rom_ok", chk_row);
        err_cnt++;
    end
    if (wb_ack && cs_q && !ok_q) begin
        $display("row %0d: acknowledge came before rom_ok", chk_row);
        err_cnt++;
    end
    cs_q = rom_cs;
    ok_q = rom_cs && rom_ok;
    if (main_stb) stb_cnt++;

    // ROM address is the CPU address below 0x8000
    if (rom_cs && rom_addr !== wb_adr[14:0]) begin
        $display("MISMATCH at %0t ns: row %0d rom_addr expected %h got %h",
                 $time, chk_row, wb_adr[14:0], rom_addr);
        err_cnt++;
    end

    if (chk_en) begin
        got  = '0;
        name = "";
        case (chk_sel)
            CK_READ:   begin name = "read data";  got = 16'(wb_dat_r);   end
            CK_FLAG:   begin name = "snd_flag";   got = 16'(snd_flag);   end
            CK_NMI:    begin name = "nmi_n";      got = 16'(nmi_n);      end
            CK_LATCH:  begin name = "main_latch"; got = 16'(main_latch); end
            CK_STBCNT: begin name = "main_stb pulses"; got = 16'(stb_cnt); end
            CK_HOLD:   begin name = "psg hold";   got = 16'(last_hold);  end
            CK_HIGH:   begin name = "psg high";   got = 16'(psg_max);    end
            CK_LOW:    begin name = "psg low";    got = 16'(psg_min);    end
            default: ;
        endcase
        if (chk_sel > CK_LOW) begin // window restart for tone levels
            psg_max = '0;
            psg_min = '1;
        end else if (chk_sel == CK_READ && !wb_ack) begin
            $display("row %0d: read data checked without an acknowledge", chk_row);
            err_cnt++;
            chk_cnt++;
        end else begin
            chk_cnt++;
            if (got !== chk_exp) begin
                $display("MISMATCH at %0t ns: row %0d %s expected %h got %h",
                         $time, chk_row, name, chk_exp, got);
                err_cnt++;
            end else begin
                $display("row %0d %s ok", chk_row, name);
            end
        end
        if (chk_sel == CK_STBCNT) stb_cnt = 0;
    end

    // cycles between psg changes and the level range
    if (psg != psg_q) begin
        last_hold = run;
        run = 1;
    end else begin
        run++;
    end
    psg_q = psg;
    if (psg > psg_max) psg_max = psg;
    if (psg < psg_min) psg_min = psg;
end

endmodule

`default_nettype wire

/* hw/snd_board.sv */
// sound board top, chains bus decode, main CPU port, tone generator and output mix
`timescale 1ns/1ns
`default_nettype none

module snd_board import snd_pkg::*; (
    input  logic      clk,
    input  logic      snd_rstn,
    input  logic      cen,
    input  logic      tokio,
    // wishbone slave
    input  addr_t     wb_adr,
    input  data_t     wb_dat_w,
    output data_t     wb_dat_r,
    input  logic      wb_we,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    output logic      wb_ack,
    // main CPU side
    input  data_t     snd_latch,
    input  logic      snd_stb,
    output data_t     main_latch,
    output logic      main_stb,
    output logic      snd_flag,
    output logic      nmi_n,
    // program ROM
    output rom_addr_t rom_addr,
    output logic      rom_cs,
    input  data_t     rom_data,
    input  logic      rom_ok,
    output sample_t   psg
);

logic       io_wr, io_rd;
logic [2:0] io_sel;
data_t      comm_dout;
logic       tone_wr;
logic [3:0] tone_reg;
data_t      bus_din; // registered write data, shared by comm and tone
data_t      tone_dout;
sample_t    tone_sum;

snd_bus u_bus (
    .clk       ( clk       ),
    .snd_rstn  ( snd_rstn  ),
    .tokio     ( tokio     ),
    .wb_adr    ( wb_adr    ),
    .wb_dat_w  ( wb_dat_w  ),
    .wb_dat_r  ( wb_dat_r  ),
    .wb_we     ( wb_we     ),
    .wb_cyc    ( wb_cyc    ),
    .wb_stb    ( wb_stb    ),
    .wb_ack    ( wb_ack    ),
    .rom_addr  ( rom_addr  ),
    .rom_cs    ( rom_cs    ),
    .rom_data  ( rom_data  ),
    .rom_ok    ( rom_ok    ),
    .io_wr     ( io_wr     ),
    .io_rd     ( io_rd     ),
    .io_sel    ( io_sel    ),
    .comm_dout ( comm_dout ),
    .tone_wr   ( tone_wr   ),
    .tone_reg  ( tone_reg  ),
    .tone_din  ( bus_din   ),
    .tone_dout ( tone_dout )
);

snd_comm u_comm (
    .clk        ( clk        ),
    .snd_rstn   ( snd_rstn   ),
    .io_wr      ( io_wr      ),
    .io_rd      ( io_rd      ),
    .io_sel     ( io_sel     ),
    .wr_data    ( bus_din    ),
    .snd_latch  ( snd_latch  ),
    .snd_stb    ( snd_stb    ),
    .comm_dout  ( comm_dout  ),
    .main_latch ( main_latch ),
    .main_stb   ( main_stb   ),
    .snd_flag   ( snd_flag   ),
    .nmi_n      ( nmi_n      )
);

tone_gen u_tone (
    .clk       ( clk       ),
    .snd_rstn  ( snd_rstn  ),
    .cen       ( cen       ),
    .tone_wr   ( tone_wr   ),
    .tone_reg  ( tone_reg  ),
    .tone_din  ( bus_din   ),
    .tone_dout ( tone_dout ),
    .tone_sum  ( tone_sum  )
);

snd_mix u_mix (
    .clk      ( clk      ),
    .snd_rstn ( snd_rstn ),
    .tokio    ( tokio    ),
    .tone_sum ( tone_sum ),
    .psg      ( psg      )
);

endmodule

`default_nettype wire

/* hw/snd_mix.sv */
// output stage, scales the tone sum to the gain of the selected board and registers it
`timescale 1ns/1ns
`default_nettype none

module snd_mix import snd_pkg::*; (
    input  logic    clk,
    input  logic    snd_rstn,
    input  logic    tokio,
    input  sample_t tone_sum,
    output sample_t psg
);

sample_t scaled;

// tokio board has a quarter of the tone gain
assign scaled = tokio ? (tone_sum >> 2) : tone_sum;

always_ff @(posedge clk, negedge snd_rstn) begin
    if (!snd_rstn) begin
        psg <= '0;
    end else begin
        psg <= scaled; // one extra cycle after tone_gen
    end
end

endmodule

`default_nettype wire

/* hw/tone_gen.sv */
// three square wave channels with period and volume registers, summed into one registered sample
`timescale 1ns/1ns
`default_nettype none

module tone_gen import snd_pkg::*; (
    input  logic       clk,
    input  logic       snd_rstn,
    input  logic       cen,
    input  logic       tone_wr,
    input  logic [3:0] tone_reg,
    input  data_t      tone_din,
    output data_t      tone_dout,
    output sample_t    tone_sum
);

period_t           period [NUM_CH];
vol_t              vol    [NUM_CH];
period_t           cnt    [NUM_CH];
logic [NUM_CH-1:0] sq;
logic [1:0]        ch_sel;
logic [1:0]        reg_off;
sample_t           mix;

assign ch_sel  = tone_reg[3:2];
assign reg_off = tone_reg[1:0];

always_ff @(posedge clk, negedge snd_rstn) begin
    if (!snd_rstn) begin
        for (int i = 0; i < NUM_CH; i++) begin
            period[i] <= '0;
            vol[i]    <= '0;
        end
    end else if (tone_wr) begin
        for (int i = 0; i < NUM_CH; i++) begin
            if (ch_sel == 2'(i)) begin
                case (reg_off)
                    REG_PER_LO: period[i][7:0] <= tone_din;
                    REG_PER_HI: period[i][9:8] <= tone_din[1:0];
                    REG_VOL:    vol[i]         <= tone_din[3:0];
                    default: ;
                endcase
            end
        end
    end
end

// half period is period+1 ticks, zero period mutes
always_ff @(posedge clk, negedge snd_rstn) begin
    if (!snd_rstn) begin
        for (int i = 0; i < NUM_CH; i++) begin
            cnt[i] <= '0;
        end
        sq <= '0;
    end else if (cen) begin
        for (int i = 0; i < NUM_CH; i++) begin
            if (period[i] == '0) begin
                cnt[i] <= '0;
                sq[i]  <= 1'b0;
            end else if (cnt[i] >= period[i]) begin // >= covers a shortened period
                cnt[i] <= '0;
                sq[i]  <= !sq[i];
            end else begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end
end

always_comb begin
    mix = '0;
    for (int i = 0; i < NUM_CH; i++) begin
        if (sq[i]) mix = mix + sample_t'({vol[i], 4'b0000}); // max 3*240 fits
    end
end

always_ff @(posedge clk, negedge snd_rstn) begin
    if (!snd_rstn) tone_sum <= '0;
    else           tone_sum <= mix;
end

// readback, missing channel or offset gives 0xff
always_comb begin
    tone_dout = 8'hff;
    for (int i = 0; i < NUM_CH; i++) begin
        if (ch_sel == 2'(i)) begin
            case (reg_off)
                REG_PER_LO: tone_dout = period[i][7:0];
                REG_PER_HI: tone_dout = {6'd0, period[i][9:8]};
                REG_VOL:    tone_dout = {4'd0, vol[i]};
                default: ;
            endcase
        end
    end
end

endmodule

`default_nettype wire

/* hw/snd_comm.sv */
// latches between main and sound CPU, pending flag and NMI gating, driven by decoded port functions
`timescale 1ns/1ns
`default_nettype none

module snd_comm import snd_pkg::*; (
    input  logic       clk,
    input  logic       snd_rstn,
    input  logic       io_wr,
    input  logic       io_rd,
    input  logic [2:0] io_sel,
    input  data_t      wr_data,
    input  data_t      snd_latch,
    input  logic       snd_stb,
    output data_t      comm_dout,
    output data_t      main_latch,
    output logic       main_stb,
    output logic       snd_flag,
    output logic       nmi_n
);

logic stb_l;
logic stb_edge;
logic nmi_en;
logic latch_rd;

assign stb_edge = snd_stb && !stb_l;
assign latch_rd = io_rd && io_sel == IO_RD_LATCH;

// snd_flag is active low, low means a command waits
always_ff @(posedge clk, negedge snd_rstn) begin
    if (!snd_rstn) begin
        stb_l    <= 1'b0;
        snd_flag <= 1'b1;
    end else begin
        stb_l <= snd_stb;
        if (stb_edge)      snd_flag <= 1'b0; // new command wins over a read
        else if (latch_rd) snd_flag <= 1'b1;
    end
end

always_ff @(posedge clk, negedge snd_rstn) begin
    if (!snd_rstn) begin
        nmi_en     <= 1'b0;
        main_latch <= 8'h00;
        main_stb   <= 1'b0;
    end else begin
        main_stb <= io_wr && (io_sel == IO_WR_REPLY_STB || io_sel == IO_WR_STB);
        if (io_wr) begin
            case (io_sel)
                IO_WR_REPLY_STB,
                IO_WR_REPLY: main_latch <= wr_data;
                IO_NMI_SET:  nmi_en     <= 1'b1;
                IO_NMI_CLR:  nmi_en     <= 1'b0;
                default: ;
            endcase
        end
    end
end

always_comb begin
    case (io_sel)
        IO_RD_LATCH:  comm_dout = snd_latch;
        IO_RD_STATUS: comm_dout = {6'h3f, main_stb, snd_flag};
        default:      comm_dout = 8'hff;
    endcase
end

// NMI while a command is pending and enabled
assign nmi_n = snd_flag || !nmi_en;

endmodule

`default_nettype wire

/* hw/snd_bus.sv */
// wishbone slave of the sound board, decodes the CPU map and serves RAM, ROM, port and tone reads
`timescale 1ns/1ns
`default_nettype none

module snd_bus import snd_pkg::*; (
    input  logic       clk,
    input  logic       snd_rstn,
    input  logic       tokio,
    input  addr_t      wb_adr,
    input  data_t      wb_dat_w,
    output data_t      wb_dat_r,
    input  logic       wb_we,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    output logic       wb_ack,
    output rom_addr_t  rom_addr,
    output logic       rom_cs,
    input  data_t      rom_data,
    input  logic       rom_ok,
    output logic       io_wr,
    output logic       io_rd,
    output logic [2:0] io_sel,
    input  data_t      comm_dout,
    output logic       tone_wr,
    output logic [3:0] tone_reg,
    output data_t      tone_din,
    input  data_t      tone_dout
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_DECODE,
    ST_ROM_WAIT,
    ST_RESPOND
} state_t;

state_t            st;
addr_t             req_adr;
data_t             req_dat;
logic              req_we;
logic [3:0]        page;
logic [RAM_AW-1:0] ram_idx;
logic              ram_hit, tone_hit, io_hit, io_nmi, io_port;
data_t             rd_mux;
data_t             ram [2**RAM_AW];

assign page    = req_adr[15:12];
assign ram_idx = req_adr[RAM_AW-1:0];
assign ram_hit = page == PAGE_RAM;
assign io_nmi  = tokio && page == PAGE_IO_TK_NMI;
assign io_port = tokio ? page == PAGE_IO_TK_PORT : page == PAGE_IO_BB;
assign io_hit  = io_nmi || io_port;
assign tone_hit = tokio ? page == PAGE_TONE_TK : page == PAGE_TONE_BB;

// one port function per access, comm never sees the address
always_comb begin
    if (io_nmi) begin
        io_sel = !req_we ? IO_NONE : (req_adr[11] ? IO_NMI_SET : IO_NMI_CLR);
    end else if (tokio) begin
        if (req_adr[11]) io_sel = req_we ? IO_WR_STB : IO_RD_STATUS;
        else             io_sel = req_we ? IO_WR_REPLY : IO_RD_LATCH;
    end else begin
        case (req_adr[1:0])
            2'd0:    io_sel = req_we ? IO_WR_REPLY_STB : IO_RD_LATCH;
            2'd1:    io_sel = req_we ? IO_NMI_SET : IO_RD_STATUS;
            2'd2:    io_sel = req_we ? IO_NMI_CLR : IO_NONE;
            default: io_sel = IO_NONE;
        endcase
    end
end

always_comb begin
    if (ram_hit)       rd_mux = ram[ram_idx];
    else if (io_hit)   rd_mux = comm_dout;
    else if (tone_hit) rd_mux = tone_dout;
    else               rd_mux = 8'hff; // unmapped, incl. second FM slot
end

always_ff @(posedge clk, negedge snd_rstn) begin
    if (!snd_rstn) begin
        st <= ST_IDLE;
    end else begin
        case (st)
            ST_IDLE: if (wb_cyc && wb_stb) begin
                st <= (wb_adr[15:12] <= PAGE_ROM) ? ST_ROM_WAIT : ST_DECODE;
            end
            ST_DECODE:   st <= ST_RESPOND;
            ST_ROM_WAIT: if (rom_ok) st <= ST_RESPOND; // only back-pressure
            default:     st <= ST_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (st == ST_IDLE) begin // request stage
        req_adr <= wb_adr;
        req_dat <= wb_dat_w;
        req_we  <= wb_we;
    end
    if (st == ST_DECODE) wb_dat_r <= rd_mux;
    if (st == ST_ROM_WAIT && rom_ok) wb_dat_r <= rom_data;
    if (wb_ack && ram_hit && req_we) ram[ram_idx] <= req_dat;
end

assign wb_ack   = st == ST_RESPOND;
assign rom_cs   = st == ST_ROM_WAIT;
assign rom_addr = req_adr[14:0];

// side effects land in the accept cycle
assign io_wr    = wb_ack && io_hit && req_we;
assign io_rd    = wb_ack && io_hit && !req_we;
assign tone_wr  = wb_ack && tone_hit && req_we;
assign tone_reg = req_adr[3:0];
assign tone_din = req_dat;

endmodule

`default_nettype wire

/* hw/snd_pkg.sv */
// shared widths, memory map pages, tone register offsets and port function codes for the sound board
`default_nettype none

package snd_pkg;

    typedef logic [15:0] addr_t;     // sound CPU address
    typedef logic [7:0]  data_t;     // one bus byte
    typedef logic [14:0] rom_addr_t; // 32 KB program ROM
    typedef logic [9:0]  period_t;   // half period in cen ticks
    typedef logic [3:0]  vol_t;
    typedef logic [9:0]  sample_t;

    localparam int RAM_AW = 12; // 4 KB work RAM
    localparam int NUM_CH = 3;

    // pages are address bits 15..12
    localparam logic [3:0] PAGE_ROM        = 4'h7; // last ROM page, ROM is 0x0000-0x7fff
    localparam logic [3:0] PAGE_RAM        = 4'h8;
    localparam logic [3:0] PAGE_TONE_BB    = 4'h9;
    localparam logic [3:0] PAGE_IO_BB      = 4'hb;
    localparam logic [3:0] PAGE_TONE_TK    = 4'hb;
    localparam logic [3:0] PAGE_IO_TK_NMI  = 4'h9;
    localparam logic [3:0] PAGE_IO_TK_PORT = 4'ha;

    // offsets inside a channel group of four
    localparam logic [1:0] REG_PER_LO = 2'd0;
    localparam logic [1:0] REG_PER_HI = 2'd1; // bits 9..8 of the period
    localparam logic [1:0] REG_VOL    = 2'd2;

    // decoded port functions, bus to comm
    localparam logic [2:0] IO_RD_LATCH     = 3'd0; // command latch, clears pending flag
    localparam logic [2:0] IO_RD_STATUS    = 3'd1;
    localparam logic [2:0] IO_WR_REPLY_STB = 3'd2; // reply latch plus strobe
    localparam logic [2:0] IO_WR_REPLY     = 3'd3;
    localparam logic [2:0] IO_WR_STB       = 3'd4;
    localparam logic [2:0] IO_NMI_SET      = 3'd5;
    localparam logic [2:0] IO_NMI_CLR      = 3'd6;
    localparam logic [2:0] IO_NONE         = 3'd7; // reads 0xff, writes ignored

endpackage

`default_nettype wire
